// File: all.f
design/cpx_pkg.sv
design/cpx_data_mem.sv
design/cpx_alu.sv
design/cpx_sequencer.sv
design/cpx_apb_regs.sv
design/cpx_top.sv
sim/cpx_assert.sv
sim/cpx_tb.sv

// File: run.sh
#!/bin/sh
# build the cpx testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module cpx_tb -f all.f -o cpx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can tally them
./obj_dir/cpx_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: sim/cpx_tb.sv
module cpx_tb;
    import cpx_pkg::*;

    // about 200 transfers, budget 250 at up to 8 cycles, doubled
    localparam int XFER_BUDGET    = 250;
    localparam int XFER_CYCLES    = 8;
    localparam int TIMEOUT_CYCLES = 2 * XFER_BUDGET * XFER_CYCLES;

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // reference memory and pointer copies
    logic [31:0] ref_mem [256];
    logic [7:0]  ld_ptr_model;
    logic [7:0]  rd_ptr_model;

    int    data_errs;
    int    proto_errs;
    int    cycle_cnt;
    string test_name;

    cpx_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // reference model
    ////////////////////
    // q1.15 with wraparound, product bits 30:15
    function automatic logic [31:0] model_alu(input logic [1:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic signed [31:0] ar, ai, br, bi;
        logic signed [31:0] rr, ii, ri, ir;
        logic [31:0]        re_w, im_w;
        logic [15:0]        re, im;
        ar = {{16{a[31]}}, a[31:16]};
        ai = {{16{a[15]}}, a[15:0]};
        br = {{16{b[31]}}, b[31:16]};
        bi = {{16{b[15]}}, b[15:0]};
        rr = ar * br;
        ii = ai * bi;
        ri = ar * bi;
        ir = ai * br;
        case (op)
            OP_ADD: begin
                re = a[31:16] + b[31:16];
                im = a[15:0] + b[15:0];
            end
            OP_SUB: begin
                re = a[31:16] - b[31:16];
                im = a[15:0] - b[15:0];
            end
            OP_MUL: begin
                re_w = rr - ii;
                im_w = ri + ir;
                re   = re_w[30:15];
                im   = im_w[30:15];
            end
            default: begin
                // a * conj(b)
                re_w = rr + ii;
                im_w = ir - ri;
                re   = re_w[30:15];
                im   = im_w[30:15];
            end
        endcase
        return {re, im};
    endfunction

    function automatic logic [31:0] make_inst(input logic [1:0] op, input logic [7:0] wb,
                                              input logic [7:0] rb, input logic [7:0] ra);
        return {1'b0, op, 5'b0, wb, rb, ra};
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            data_errs++;
            $display("ERR %s: expected %h, got %h", what, exp, got);
        end
    endtask

    ////////////////////
    // apb master
    ////////////////////
    // starts and ends 1 unit after a rising edge
    task automatic run_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        logic done;
        logic err;
        done  = 1'b0;
        err   = 1'b0;
        rdata = '0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        // sample on the falling edge, outputs settled
        while (!done) begin
            @(negedge clk);
            done  = apb_rsp.pready;
            err   = apb_rsp.pslverr;
            rdata = apb_rsp.prdata;
            @(posedge clk);
            #1;
        end
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        check_val($sformatf("%s pslverr", test_name), {31'b0, exp_err}, {31'b0, err});
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] unused;
        run_xfer(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
        run_xfer(1'b0, addr, 32'd0, exp_err, data);
    endtask

    ////////////////////
    // register helpers
    ////////////////////
    task automatic set_load_ptr(input logic [7:0] p);
        apb_write(REG_LOAD_PTR, {24'b0, p}, 1'b0);
        ld_ptr_model = p;
    endtask

    task automatic set_read_ptr(input logic [7:0] p);
        apb_write(REG_READ_PTR, {24'b0, p}, 1'b0);
        rd_ptr_model = p;
    endtask

    task automatic load_word(input logic [31:0] w);
        apb_write(REG_LOAD_DATA, w, 1'b0);
        ref_mem[ld_ptr_model] = w;
        ld_ptr_model = ld_ptr_model + 8'd1;
    endtask

    // hazards are stalled, so the model updates in issue order
    task automatic issue_op(input logic [1:0] op, input logic [7:0] ra, input logic [7:0] rb,
                            input logic [7:0] wb);
        apb_write(REG_INSTR, make_inst(op, wb, rb, ra), 1'b0);
        ref_mem[wb] = model_alu(op, ref_mem[ra], ref_mem[rb]);
    endtask

    task automatic read_and_check(input string what);
        logic [31:0] got;
        apb_read(REG_READ_DATA, 1'b0, got);
        check_val(what, ref_mem[rd_ptr_model], got);
        rd_ptr_model = rd_ptr_model + 8'd1;
    endtask

    task automatic check_block(input string what, input logic [7:0] start, input int n);
        set_read_ptr(start);
        for (int i = 0; i < n; i++) begin
            read_and_check($sformatf("%s[%0d]", what, i));
        end
    endtask

    task automatic check_reg(input string what, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        apb_read(addr, 1'b0, got);
        check_val(what, exp, got);
    endtask

    ////////////////////
    // watchdog
    ////////////////////
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("Done: errors found");
        $finish;
    end

    ////////////////////
    // tests
    ////////////////////
    initial begin
        logic [31:0] got;
        logic [1:0]  chain_ops [8];
        void'($urandom(32'h7517));
        rst          = 1'b1;
        apb_req      = '0;
        data_errs    = 0;
        proto_errs   = 0;
        ld_ptr_model = '0;
        rd_ptr_model = '0;
        test_name    = "reset";
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values, then load and read back in order
        check_reg("status after reset", REG_STATUS, 32'd0);
        check_reg("load ptr after reset", REG_LOAD_PTR, 32'd0);
        check_reg("read ptr after reset", REG_READ_PTR, 32'd0);
        test_name = "load";
        for (int i = 0; i < 16; i++) begin
            load_word($urandom);
        end
        check_block("load", 8'h00, 16);
        check_reg("load ptr count", REG_LOAD_PTR, 32'd16);
        check_reg("read ptr count", REG_READ_PTR, 32'd16);

        // add and sub, last pair wraps in both parts
        test_name = "add_sub";
        set_load_ptr(8'h20);
        for (int i = 0; i < 8; i++) begin
            load_word($urandom);
        end
        load_word(32'h7FFF_8000);
        load_word(32'h0001_0001);
        for (int i = 0; i < 4; i++) begin
            issue_op(OP_ADD, 8'(8'h20 + i), 8'(8'h27 - i), 8'(8'h40 + i));
            issue_op(OP_SUB, 8'(8'h20 + i), 8'(8'h24 + i), 8'(8'h44 + i));
        end
        issue_op(OP_ADD, 8'h28, 8'h29, 8'h48);
        issue_op(OP_SUB, 8'h28, 8'h29, 8'h49);
        check_block("add_sub", 8'h40, 10);

        // products with 0x8000 corners, i = 0 squares its own operand
        test_name = "mul";
        set_load_ptr(8'h50);
        load_word(32'h8000_8000);
        load_word(32'h8000_0000);
        load_word(32'h0000_8000);
        load_word(32'h7FFF_7FFF);
        for (int i = 0; i < 4; i++) begin
            load_word($urandom);
        end
        for (int i = 0; i < 8; i++) begin
            issue_op(OP_MUL, 8'(8'h50 + i), 8'(8'h50 + (i * 3) % 8), 8'(8'h60 + i));
            issue_op(OP_CMUL, 8'(8'h50 + i), 8'(8'h50 + (i * 5) % 8), 8'(8'h68 + i));
        end
        check_block("mul", 8'h60, 16);

        // dependent chain, then the same ops with independent work between
        test_name = "chain";
        set_load_ptr(8'h80);
        for (int i = 0; i < 4; i++) begin
            load_word($urandom);
        end
        for (int k = 0; k < 8; k++) begin
            chain_ops[k] = 2'($urandom_range(3));
            issue_op(chain_ops[k], (k == 0) ? 8'h80 : 8'(8'h8F + k), 8'h81, 8'(8'h90 + k));
        end
        for (int k = 0; k < 8; k++) begin
            issue_op(chain_ops[k], (k == 0) ? 8'h80 : 8'(8'h9F + k), 8'h81, 8'(8'hA0 + k));
            issue_op(2'($urandom_range(3)), 8'h82, 8'h83, 8'(8'hB0 + k));
        end
        check_block("chain", 8'h90, 8);
        check_block("interleave", 8'hA0, 8);
        // 0xb7 went in last, so the pipe is empty after it
        check_block("independent", 8'hB0, 8);
        check_reg("status after drain", REG_STATUS, 32'd0);

        // readback and load against in-flight writebacks
        test_name = "hazard";
        set_load_ptr(8'hC0);
        load_word($urandom);
        load_word($urandom);
        set_read_ptr(8'hC0);
        issue_op(OP_ADD, 8'h20, 8'h21, 8'hC0);
        read_and_check("read in flight");
        set_load_ptr(8'hC1);
        issue_op(OP_MUL, 8'h54, 8'h55, 8'hC1);
        load_word(32'h1234_5678);
        check_block("load in flight", 8'hC0, 2);

        // error responses, no side effects
        test_name = "bad_access";
        set_read_ptr(8'h40);
        set_load_ptr(8'h44);
        apb_read(8'h18, 1'b1, got);
        apb_write(8'h18, $urandom, 1'b1);
        apb_write(REG_READ_DATA, $urandom, 1'b1);
        apb_write(REG_STATUS, $urandom, 1'b1);
        apb_read(REG_LOAD_DATA, 1'b1, got);
        apb_read(REG_INSTR, 1'b1, got);
        check_reg("load ptr kept", REG_LOAD_PTR, 32'h44);
        check_reg("read ptr kept", REG_READ_PTR, 32'h40);
        check_block("mem kept", 8'h40, 10);

        proto_errs = dut0.u_apb_chk.phase_fails + dut0.u_apb_chk.hold_fails
                   + dut0.u_apb_chk.err_fails;
        $display("closing: %0d data errors, %0d protocol errors", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim/cpx_assert.sv
module cpx_assert (
    input logic              clk,
    input logic              rst,
    input cpx_pkg::apb_req_t apb_req,
    input cpx_pkg::apb_rsp_t apb_rsp
);

    // failure tallies, one per property
    int phase_fails = 0;
    int hold_fails  = 0;
    int err_fails   = 0;

    logic access;

    assign access = apb_req.psel && apb_req.penable;

    ////////////////////
    // response timing
    ////////////////////
    rsp_in_access: assert property (
        @(posedge clk) disable iff (rst)
        (apb_rsp.pready || apb_rsp.pslverr) |-> access
    ) else begin
        phase_fails++;
        $error("pready or pslverr raised outside an access phase");
    end

    // slave error only qualifies a completing cycle
    err_with_ready: assert property (
        @(posedge clk) disable iff (rst)
        apb_rsp.pslverr |-> apb_rsp.pready
    ) else begin
        err_fails++;
        $error("pslverr high while pready is low");
    end

    ////////////////////
    // master side
    ////////////////////
    // request fields frozen until the slave completes
    req_hold: assert property (
        @(posedge clk) disable iff (rst)
        (apb_req.psel && !apb_rsp.pready) |=>
            ($stable(apb_req.paddr) && $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
    ) else begin
        hold_fails++;
        $error("apb request fields changed before pready");
    end

endmodule

bind cpx_top cpx_assert u_apb_chk (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
);

// File: design/cpx_top.sv
module cpx_top (
    input  logic              clk,
    input  logic              rst,
    input  cpx_pkg::apb_req_t apb_req,
    output cpx_pkg::apb_rsp_t apb_rsp
);
    import cpx_pkg::*;

    // regs <-> sequencer
    cpx_req_e  req_kind;
    cpx_inst_t req_inst;
    logic      grant;

    // pointer access
    logic                     ptr_we;
    logic                     ptr_sel;
    logic [DM_ADDR_WIDTH-1:0] ptr_wdata;
    logic [DM_ADDR_WIDTH-1:0] load_ptr;
    logic [DM_ADDR_WIDTH-1:0] read_ptr;

    // memory control
    logic                     load_we;
    logic                     inst_v;
    logic                     rd_v;
    logic                     wb_we;
    logic [DM_ADDR_WIDTH-1:0] ra_addr;
    logic [DM_ADDR_WIDTH-1:0] rb_addr;
    logic [DM_ADDR_WIDTH-1:0] wb_addr;
    logic [2:0]               inflight;

    // datapath
    cpx_t    rdata0;
    cpx_t    rdata1;
    cpx_t    result;
    cpx_op_e op_d;
    logic    op_v;
    logic    alu_v;

    cpx_apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .grant     (grant),
        .rdata0    (rdata0),
        .load_ptr  (load_ptr),
        .read_ptr  (read_ptr),
        .inflight  (inflight),
        .apb_rsp   (apb_rsp),
        .req_kind  (req_kind),
        .req_inst  (req_inst),
        .ptr_we    (ptr_we),
        .ptr_sel   (ptr_sel),
        .ptr_wdata (ptr_wdata)
    );

    cpx_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .req_kind (req_kind),
        .req_inst (req_inst),
        .load_ptr (load_ptr),
        .read_ptr (read_ptr),
        .alu_v    (alu_v),
        .grant    (grant),
        .load_we  (load_we),
        .inst_v   (inst_v),
        .rd_v     (rd_v),
        .wb_we    (wb_we),
        .ra_addr  (ra_addr),
        .rb_addr  (rb_addr),
        .wb_addr  (wb_addr),
        .op_d     (op_d),
        .op_v     (op_v),
        .inflight (inflight)
    );

    // load word comes straight off the write data bus
    cpx_data_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .load_we   (load_we),
        .inst_v    (inst_v),
        .rd_v      (rd_v),
        .wb_we     (wb_we),
        .ra_addr   (ra_addr),
        .rb_addr   (rb_addr),
        .wb_addr   (wb_addr),
        .ptr_we    (ptr_we),
        .ptr_sel   (ptr_sel),
        .ptr_wdata (ptr_wdata),
        .load_data (apb_req.pwdata),
        .result    (result),
        .rdata0    (rdata0),
        .rdata1    (rdata1),
        .load_ptr  (load_ptr),
        .read_ptr  (read_ptr)
    );

    cpx_alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .in_v   (op_v),
        .op     (op_d),
        .a      (rdata0),
        .b      (rdata1),
        .out_v  (alu_v),
        .result (result)
    );

endmodule

// File: design/cpx_apb_regs.sv
module cpx_apb_regs (
    input  logic                              clk,
    input  logic                              rst,
    input  cpx_pkg::apb_req_t                 apb_req,
    input  logic                              grant,
    input  cpx_pkg::cpx_t                     rdata0,
    input  logic [cpx_pkg::DM_ADDR_WIDTH-1:0] load_ptr,
    input  logic [cpx_pkg::DM_ADDR_WIDTH-1:0] read_ptr,
    input  logic [2:0]                        inflight,
    output cpx_pkg::apb_rsp_t                 apb_rsp,
    output cpx_pkg::cpx_req_e                 req_kind,
    output cpx_pkg::cpx_inst_t                req_inst,
    output logic                              ptr_we,
    output logic                              ptr_sel,
    output logic [cpx_pkg::DM_ADDR_WIDTH-1:0] ptr_wdata
);
    import cpx_pkg::*;

    logic access;
    logic wr;
    logic rd_pend;

    assign access = apb_req.psel && apb_req.penable;
    assign wr     = apb_req.pwrite;

    // instruction word is the write data as is
    assign req_inst  = cpx_inst_t'(apb_req.pwdata[INST_WIDTH-1:0]);
    assign ptr_wdata = apb_req.pwdata[DM_ADDR_WIDTH-1:0];

    ////////////////////
    // decode
    ////////////////////
    always_comb begin
        apb_rsp  = '0;
        req_kind = REQ_NONE;
        ptr_we   = 1'b0;
        ptr_sel  = 1'b0;
        if (access) begin
            case (apb_req.paddr)
                REG_LOAD_PTR, REG_READ_PTR: begin
                    apb_rsp.pready = 1'b1;
                    ptr_sel        = (apb_req.paddr == REG_READ_PTR);
                    ptr_we         = wr;
                    if (!wr) begin
                        apb_rsp.prdata[DM_ADDR_WIDTH-1:0] = ptr_sel ? read_ptr : load_ptr;
                    end
                end
                REG_LOAD_DATA, REG_INSTR: begin
                    if (wr) begin
                        // done once the sequencer lets it in
                        req_kind       = (apb_req.paddr == REG_INSTR) ? REQ_ISSUE : REQ_LOAD;
                        apb_rsp.pready = grant;
                    end else begin
                        apb_rsp.pready  = 1'b1;
                        apb_rsp.pslverr = 1'b1;
                    end
                end
                REG_READ_DATA: begin
                    if (wr) begin
                        apb_rsp.pready  = 1'b1;
                        apb_rsp.pslverr = 1'b1;
                    end else if (rd_pend) begin
                        // data registered on the grant edge
                        apb_rsp.pready = 1'b1;
                        apb_rsp.prdata = rdata0;
                    end else begin
                        req_kind = REQ_READ;
                    end
                end
                REG_STATUS: begin
                    apb_rsp.pready  = 1'b1;
                    apb_rsp.pslverr = wr;
                    if (!wr) begin
                        apb_rsp.prdata[2:0] = inflight;
                    end
                end
                default: begin
                    apb_rsp.pready  = 1'b1;
                    apb_rsp.pslverr = 1'b1;
                end
            endcase
        end
    end

    ////////////////////
    // readback wait state
    ////////////////////
    // set on a granted read, gone after the completing cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else if (rd_pend) begin
            rd_pend <= 1'b0;
        end else if (req_kind == REQ_READ && grant) begin
            rd_pend <= 1'b1;
        end
    end

endmodule

// File: design/cpx_sequencer.sv
module cpx_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  cpx_pkg::cpx_req_e                 req_kind,
    input  cpx_pkg::cpx_inst_t                req_inst,
    input  logic [cpx_pkg::DM_ADDR_WIDTH-1:0] load_ptr,
    input  logic [cpx_pkg::DM_ADDR_WIDTH-1:0] read_ptr,
    input  logic                              alu_v,
    output logic                              grant,
    output logic                              load_we,
    output logic                              inst_v,
    output logic                              rd_v,
    output logic                              wb_we,
    output logic [cpx_pkg::DM_ADDR_WIDTH-1:0] ra_addr,
    output logic [cpx_pkg::DM_ADDR_WIDTH-1:0] rb_addr,
    output logic [cpx_pkg::DM_ADDR_WIDTH-1:0] wb_addr,
    output cpx_pkg::cpx_op_e                  op_d,
    output logic                              op_v,
    output logic [2:0]                        inflight
);
    import cpx_pkg::*;

    // writeback delay line, entry 0 is the newest
    logic [WB_DEPTH-1:0]      wb_v;
    logic [DM_ADDR_WIDTH-1:0] wb_a [WB_DEPTH];

    logic ra_hit;
    logic rb_hit;
    logic ld_hit;
    logic rd_hit;

    ////////////////////
    // hazard check
    ////////////////////
    always_comb begin
        ra_hit   = 1'b0;
        rb_hit   = 1'b0;
        ld_hit   = 1'b0;
        rd_hit   = 1'b0;
        inflight = '0;
        for (int i = 0; i < WB_DEPTH; i++) begin
            if (wb_v[i]) begin
                inflight = inflight + 3'd1;
                ra_hit   = ra_hit | (wb_a[i] == req_inst.ra_addr);
                rb_hit   = rb_hit | (wb_a[i] == req_inst.rb_addr);
                ld_hit   = ld_hit | (wb_a[i] == load_ptr);
                rd_hit   = rd_hit | (wb_a[i] == read_ptr);
            end
        end
    end

    // single write port, a load also waits out a writeback cycle
    always_comb begin
        case (req_kind)
            REQ_LOAD:  grant = !ld_hit && !wb_we;
            REQ_ISSUE: grant = !ra_hit && !rb_hit;
            REQ_READ:  grant = !rd_hit;
            default:   grant = 1'b0;
        endcase
    end

    assign load_we = grant && (req_kind == REQ_LOAD);
    assign inst_v  = grant && (req_kind == REQ_ISSUE);
    assign rd_v    = grant && (req_kind == REQ_READ);
    assign ra_addr = req_inst.ra_addr;
    assign rb_addr = req_inst.rb_addr;

    ////////////////////
    // delay line
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_v <= '0;
        end else begin
            wb_v <= {wb_v[WB_DEPTH-2:0], inst_v};
        end
    end

    always_ff @(posedge clk) begin
        wb_a[0] <= req_inst.wb_addr;
        for (int i = 1; i < WB_DEPTH; i++) begin
            wb_a[i] <= wb_a[i-1];
        end
        // op lines up with the registered operands
        op_d <= req_inst.op;
    end

    // entry 0 is valid exactly when operands leave the memory
    assign op_v    = wb_v[0];
    assign wb_we   = wb_v[WB_DEPTH-1] && alu_v;
    assign wb_addr = wb_a[WB_DEPTH-1];

endmodule

// File: design/cpx_alu.sv
module cpx_alu (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_v,
    input  cpx_pkg::cpx_op_e op,
    input  cpx_pkg::cpx_t    a,
    input  cpx_pkg::cpx_t    b,
    output logic             out_v,
    output cpx_pkg::cpx_t    result
);
    import cpx_pkg::*;

    // stage 1 operands
    cpx_t    a_s1;
    cpx_t    b_s1;
    cpx_op_e op_s1;

    // stage 2 cross products and plain sums
    cpx_op_e                 op_s2;
    logic signed [31:0]      p_rr;
    logic signed [31:0]      p_ii;
    logic signed [31:0]      p_ri;
    logic signed [31:0]      p_ir;
    logic [DATA_WIDTH-1:0]   sum_re;
    logic [DATA_WIDTH-1:0]   sum_im;

    // stage 3 combine
    logic signed [31:0]      re_full;
    logic signed [31:0]      im_full;

    logic [ALU_LATENCY-1:0]  v_pipe;

    ////////////////////
    // valid pipe
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[ALU_LATENCY-2:0], in_v};
        end
    end

    assign out_v = v_pipe[ALU_LATENCY-1];

    ////////////////////
    // stage 1
    ////////////////////
    always_ff @(posedge clk) begin
        a_s1  <= a;
        b_s1  <= b;
        op_s1 <= op;
    end

    ////////////////////
    // stage 2
    ////////////////////
    always_ff @(posedge clk) begin
        op_s2 <= op_s1;
        // 16x16 signed, fits in 32 bits even for 0x8000 squared
        p_rr  <= $signed(a_s1.re) * $signed(b_s1.re);
        p_ii  <= $signed(a_s1.im) * $signed(b_s1.im);
        p_ri  <= $signed(a_s1.re) * $signed(b_s1.im);
        p_ir  <= $signed(a_s1.im) * $signed(b_s1.re);
        // wraps mod 2^16 per part
        if (op_s1 == OP_SUB) begin
            sum_re <= a_s1.re - b_s1.re;
            sum_im <= a_s1.im - b_s1.im;
        end else begin
            sum_re <= a_s1.re + b_s1.re;
            sum_im <= a_s1.im + b_s1.im;
        end
    end

    ////////////////////
    // stage 3
    ////////////////////
    always_comb begin
        // (ar + j ai)(br + j bi)
        re_full = p_rr - p_ii;
        im_full = p_ri + p_ir;
        // conj(b) flips the sign of every b.im term
        if (op_s2 == OP_CMUL) begin
            re_full = p_rr + p_ii;
            im_full = p_ir - p_ri;
        end
    end

    // bit 31 may wrap, 30:15 is the q1.15 result
    always_ff @(posedge clk) begin
        if (op_s2 == OP_ADD || op_s2 == OP_SUB) begin
            result.re <= sum_re;
            result.im <= sum_im;
        end else begin
            result.re <= re_full[30:15];
            result.im <= im_full[30:15];
        end
    end

endmodule

// File: design/cpx_data_mem.sv
module cpx_data_mem (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               load_we,
    input  logic                               inst_v,
    input  logic                               rd_v,
    input  logic                               wb_we,
    input  logic [cpx_pkg::DM_ADDR_WIDTH-1:0]  ra_addr,
    input  logic [cpx_pkg::DM_ADDR_WIDTH-1:0]  rb_addr,
    input  logic [cpx_pkg::DM_ADDR_WIDTH-1:0]  wb_addr,
    input  logic                               ptr_we,
    input  logic                               ptr_sel,
    input  logic [cpx_pkg::DM_ADDR_WIDTH-1:0]  ptr_wdata,
    input  cpx_pkg::cpx_t                      load_data,
    input  cpx_pkg::cpx_t                      result,
    output cpx_pkg::cpx_t                      rdata0,
    output cpx_pkg::cpx_t                      rdata1,
    output logic [cpx_pkg::DM_ADDR_WIDTH-1:0]  load_ptr,
    output logic [cpx_pkg::DM_ADDR_WIDTH-1:0]  read_ptr
);
    import cpx_pkg::*;

    localparam int DEPTH = 2 ** DM_ADDR_WIDTH;

    // block ram, no reset on contents
    cpx_t mem [DEPTH];

    logic [DM_ADDR_WIDTH-1:0] addr0;

    ////////////////////
    // write port
    ////////////////////
    // writeback and load never land in the same cycle
    always_ff @(posedge clk) begin
        if (wb_we) begin
            mem[wb_addr] <= result;
        end else if (load_we) begin
            mem[load_ptr] <= load_data;
        end
    end

    ////////////////////
    // read ports
    ////////////////////
    // port 0 is shared between operand a and readback
    assign addr0 = inst_v ? ra_addr : read_ptr;

    // registered reads, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (inst_v || rd_v) begin
            rdata0 <= mem[addr0];
        end
        if (inst_v) begin
            rdata1 <= mem[rb_addr];
        end
    end

    ////////////////////
    // pointers
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            load_ptr <= '0;
            read_ptr <= '0;
        end else begin
            // host write wins over auto increment
            if (ptr_we && !ptr_sel) begin
                load_ptr <= ptr_wdata;
            end else if (load_we) begin
                load_ptr <= load_ptr + 1'b1;
            end
            if (ptr_we && ptr_sel) begin
                read_ptr <= ptr_wdata;
            end else if (rd_v) begin
                read_ptr <= read_ptr + 1'b1;
            end
        end
    end

endmodule

// File: design/cpx_pkg.sv
package cpx_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int DATA_WIDTH    = 16;
    localparam int WORD_WIDTH    = 32;
    localparam int DM_ADDR_WIDTH = 8;
    localparam int INST_WIDTH    = 32;
    localparam int ALU_LATENCY   = 3;
    // writeback tracking covers the operand read plus every alu stage
    localparam int WB_DEPTH      = ALU_LATENCY + 1;

    ////////////////////
    // payload types
    ////////////////////
    // q1.15 parts, re in the upper half
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] re;
        logic signed [DATA_WIDTH-1:0] im;
    } cpx_t;

    // OP_CMUL is a * conj(b)
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_MUL  = 2'd2,
        OP_CMUL = 2'd3
    } cpx_op_e;

    typedef struct packed {
        logic                     spare_hi;
        cpx_op_e                  op;
        logic [4:0]               spare_lo;
        logic [DM_ADDR_WIDTH-1:0] wb_addr;
        logic [DM_ADDR_WIDTH-1:0] rb_addr;
        logic [DM_ADDR_WIDTH-1:0] ra_addr;
    } cpx_inst_t;

    ////////////////////
    // apb bus
    ////////////////////
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [7:0]            paddr;
        logic [WORD_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // memory-side requests from the register block
    typedef enum logic [1:0] {
        REQ_NONE  = 2'd0,
        REQ_LOAD  = 2'd1,
        REQ_ISSUE = 2'd2,
        REQ_READ  = 2'd3
    } cpx_req_e;

    // register byte offsets
    localparam logic [7:0] REG_LOAD_PTR  = 8'h00;
    localparam logic [7:0] REG_LOAD_DATA = 8'h04;
    localparam logic [7:0] REG_INSTR     = 8'h08;
    localparam logic [7:0] REG_READ_PTR  = 8'h0C;
    localparam logic [7:0] REG_READ_DATA = 8'h10;
    localparam logic [7:0] REG_STATUS    = 8'h14;

endpackage
